// ==== rtl/pipe_pkg.sv ====
package pipe_pkg;

	////////////////////////////////////////
	// Sizes

	localparam int NUM_CH     = 4;                 // DAQ channels
	localparam int SAMPLE_W   = 96;                // One channel word
	localparam int GROUP_W    = 2 * SAMPLE_W;      // Two channels per group
	localparam int PDEPTH_W   = 9;
	localparam int OCC_W      = 10;
	localparam int FIFO_AW    = 9;
	localparam int FIFO_DEPTH = 1 << FIFO_AW;      // 512 entries

	////////////////////////////////////////
	// Latency

	localparam int RE_SYNC_STAGES = 3;             // Read-enable delay chain
	localparam int OUT_REGS       = 2;             // FIFO read reg plus group reg

	// Cycles beyond pdepth from input word to group output
	localparam int PIPE_LAT = RE_SYNC_STAGES + OUT_REGS;

	////////////////////////////////////////
	// Types

	typedef logic [SAMPLE_W-1:0] sample_t;
	typedef logic [GROUP_W-1:0]  group_t;          // Channel 1 in upper half
	typedef logic [PDEPTH_W-1:0] pdepth_t;
	typedef logic [OCC_W-1:0]    occ_t;
	typedef logic [FIFO_AW-1:0]  fifo_addr_t;

	typedef enum logic [1:0] {
		ST_IDLE,                                   // Wait for first restart
		ST_CLEAR,                                  // One cycle, FIFO flushed
		ST_FILL,                                   // Write only
		ST_RUN                                     // Write and read
	} start_state_t;

endpackage

// ==== rtl/pipe_fifo.sv ====
`timescale 1ns/1ps

module pipe_fifo (
	input  logic              CLK160,
	input  logic              trst,
	input  logic              clr_i,
	input  logic              wr_en_i,
	input  logic              rd_en_i,
	input  pipe_pkg::sample_t din_i,
	output pipe_pkg::sample_t dout_o,
	output logic              full_o,
	output logic              empty_o
);

	pipe_pkg::sample_t    mem [pipe_pkg::FIFO_DEPTH];
	pipe_pkg::fifo_addr_t wr_ptr;
	pipe_pkg::fifo_addr_t rd_ptr;
	pipe_pkg::occ_t       cnt;                     // Entries held
	logic                 do_wr;
	logic                 do_rd;

	assign full_o  = (cnt == pipe_pkg::FIFO_DEPTH);
	assign empty_o = (cnt == '0);

	// Overflow and underflow are blocked here, the pointers never wrap onto live data
	assign do_wr = wr_en_i & ~full_o & ~clr_i;
	assign do_rd = rd_en_i & ~empty_o & ~clr_i;

	////////////////////////////////////////
	// Storage

	always_ff @(posedge CLK160) begin
		if (do_wr)
			mem[wr_ptr] <= din_i;
	end

	////////////////////////////////////////
	// Pointers and fill count

	always_ff @(posedge CLK160 or posedge trst) begin
		if (trst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			cnt    <= '0;
		end else if (clr_i) begin                  // Flush on pipeline restart
			wr_ptr <= '0;
			rd_ptr <= '0;
			cnt    <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_rd, do_wr})
				2'b01:   cnt <= cnt + 1'b1;
				2'b10:   cnt <= cnt - 1'b1;
				default: cnt <= cnt;
			endcase
		end
	end

	// Registered read port, holds last word when idle
	always_ff @(posedge CLK160 or posedge trst) begin
		if (trst)
			dout_o <= '0;
		else if (do_rd)
			dout_o <= mem[rd_ptr];
	end

endmodule

// ==== rtl/pipe_start_fsm.sv ====
`timescale 1ns/1ps

module pipe_start_fsm (
	input  logic              CLK160,
	input  logic              trst,
	input  logic              restart_i,
	input  pipe_pkg::pdepth_t pdepth_i,
	output logic              wr_en_o,
	output logic              rd_en_o,
	output logic              clr_o,
	output logic              run_o
);

	pipe_pkg::start_state_t       state;
	pipe_pkg::pdepth_t            fill_cnt;        // Writes done in ST_FILL
	logic [pipe_pkg::PIPE_LAT-1:0] run_sr;         // Tracks words through read path
	logic                         fill_done;

	// Wider compare so a depth of zero still leaves ST_FILL
	assign fill_done = ({1'b0, fill_cnt} + 10'd1) >= {1'b0, pdepth_i};

	always_ff @(posedge CLK160 or posedge trst) begin
		if (trst) begin
			state    <= pipe_pkg::ST_IDLE;
			fill_cnt <= '0;
		end else if (restart_i) begin              // Restart wins in any state
			state    <= pipe_pkg::ST_CLEAR;
			fill_cnt <= '0;
		end else begin
			case (state)
				pipe_pkg::ST_IDLE:  state <= pipe_pkg::ST_IDLE;
				pipe_pkg::ST_CLEAR: begin
					state    <= pipe_pkg::ST_FILL;
					fill_cnt <= '0;
				end
				pipe_pkg::ST_FILL: begin
					fill_cnt <= fill_cnt + 1'b1;
					if (fill_done)
						state <= pipe_pkg::ST_RUN;
				end
				pipe_pkg::ST_RUN:   state <= pipe_pkg::ST_RUN;
				default:            state <= pipe_pkg::ST_IDLE;
			endcase
		end
	end

	assign clr_o   = (state == pipe_pkg::ST_CLEAR);
	assign wr_en_o = (state == pipe_pkg::ST_FILL) | (state == pipe_pkg::ST_RUN);
	assign rd_en_o = (state == pipe_pkg::ST_RUN);

	////////////////////////////////////////
	// Run flag aligned to group output

	always_ff @(posedge CLK160 or posedge trst) begin
		if (trst)
			run_sr <= '0;
		else if (state == pipe_pkg::ST_CLEAR)     // Drop stale history
			run_sr <= '0;
		else
			run_sr <= {run_sr[pipe_pkg::PIPE_LAT-2:0], rd_en_o};
	end

	// Falls as soon as a restart has moved the machine out of ST_RUN
	assign run_o = run_sr[pipe_pkg::PIPE_LAT-1] & rd_en_o;

endmodule

// ==== rtl/pipe_channel.sv ====
`timescale 1ns/1ps

module pipe_channel (
	input  logic              CLK160,
	input  logic              trst,
	input  logic              restart_i,
	input  pipe_pkg::pdepth_t pdepth_i,
	input  pipe_pkg::sample_t din_i,
	output pipe_pkg::sample_t dout_o,
	output pipe_pkg::occ_t    occ_o,
	output logic              run_o
);

	logic                               wr_en;
	logic                               rd_en_raw;
	logic                               clr;
	logic [pipe_pkg::RE_SYNC_STAGES-1:0] re_sync;   // Read-enable delay chain
	logic                               fifo_rd;
	logic                               fifo_full;

	pipe_start_fsm u_start_fsm (
		.CLK160    (CLK160),
		.trst      (trst),
		.restart_i (restart_i),
		.pdepth_i  (pdepth_i),
		.wr_en_o   (wr_en),
		.rd_en_o   (rd_en_raw),
		.clr_o     (clr),
		.run_o     (run_o)
	);

	////////////////////////////////////////
	// Read enable delay

	// Cleared with the FIFO so a restart does not read the fresh, empty FIFO
	always_ff @(posedge CLK160 or posedge trst) begin
		if (trst)
			re_sync <= '0;
		else if (clr)
			re_sync <= '0;
		else
			re_sync <= {re_sync[pipe_pkg::RE_SYNC_STAGES-2:0], rd_en_raw};
	end

	assign fifo_rd = re_sync[pipe_pkg::RE_SYNC_STAGES-1];

	pipe_fifo u_fifo (
		.CLK160  (CLK160),
		.trst    (trst),
		.clr_i   (clr),
		.wr_en_i (wr_en),
		.rd_en_i (fifo_rd),
		.din_i   (din_i),
		.dout_o  (dout_o),
		.full_o  (fifo_full),
		.empty_o ()
	);

	////////////////////////////////////////
	// Occupancy

	always_ff @(posedge CLK160 or posedge trst) begin
		if (trst)
			occ_o <= '0;
		else if (clr)
			occ_o <= '0;
		else
			case ({fifo_rd, wr_en})
				2'b01:   occ_o <= occ_o + 1'b1;   // Write only
				2'b10:   occ_o <= occ_o - 1'b1;   // Read only
				default: occ_o <= occ_o;
			endcase
	end

endmodule

// ==== rtl/pipe_restart_ctrl.sv ====
`timescale 1ns/1ps

module pipe_restart_ctrl (
	input  logic                        CLK160,
	input  logic                        trst,
	input  logic                        restart_req_i,
	input  logic [pipe_pkg::NUM_CH-1:0] chan_run_i,
	output logic                        restart_o,
	output logic                        restart_ack_o
);

	typedef enum logic {
		HS_IDLE,                                   // Ack low, waiting for request
		HS_WAIT                                    // Restart issued
	} hs_state_t;

	hs_state_t state;
	logic      all_run;

	assign all_run = &chan_run_i;

	// HS_IDLE is only entered with the request low, so a request seen there is a new edge
	always_ff @(posedge CLK160 or posedge trst) begin
		if (trst) begin
			state         <= HS_IDLE;
			restart_o     <= 1'b0;
			restart_ack_o <= 1'b0;
		end else begin
			case (state)
				HS_IDLE: begin
					restart_ack_o <= 1'b0;
					restart_o     <= restart_req_i;    // One pulse per request
					if (restart_req_i)
						state <= HS_WAIT;
				end
				HS_WAIT: begin
					restart_o <= 1'b0;
					// Run flags still show the old run while the pulse is out
					restart_ack_o <= restart_req_i & all_run & ~restart_o;
					if (!restart_req_i)
						state <= HS_IDLE;
				end
				default: begin
					state         <= HS_IDLE;
					restart_o     <= 1'b0;
					restart_ack_o <= 1'b0;
				end
			endcase
		end
	end

endmodule

// ==== rtl/pipeline_gen.sv ====
`timescale 1ns/1ps

module pipeline_gen (
	input  logic                        CLK160,
	input  logic                        trst,
	input  logic                        restart_req_i,
	output logic                        restart_ack_o,
	input  logic [pipe_pkg::NUM_CH-1:0] restart_ch_i,
	input  pipe_pkg::pdepth_t           pdepth_i,
	input  pipe_pkg::sample_t           daq_ch0_i,
	input  pipe_pkg::sample_t           daq_ch1_i,
	input  pipe_pkg::sample_t           daq_ch2_i,
	input  pipe_pkg::sample_t           daq_ch3_i,
	output pipe_pkg::group_t            grp0_o,
	output pipe_pkg::group_t            grp1_o,
	output pipe_pkg::occ_t              occ0_o,
	output pipe_pkg::occ_t              occ1_o,
	output pipe_pkg::occ_t              occ2_o,
	output pipe_pkg::occ_t              occ3_o,
	output logic [pipe_pkg::NUM_CH-1:0] chan_run_o
);

	logic                        glob_restart;
	logic [pipe_pkg::NUM_CH-1:0] ch_restart;
	pipe_pkg::sample_t           daq     [pipe_pkg::NUM_CH];
	pipe_pkg::sample_t           ch_dout [pipe_pkg::NUM_CH];
	pipe_pkg::occ_t              ch_occ  [pipe_pkg::NUM_CH];

	pipe_restart_ctrl u_restart_ctrl (
		.CLK160        (CLK160),
		.trst          (trst),
		.restart_req_i (restart_req_i),
		.chan_run_i    (chan_run_o),
		.restart_o     (glob_restart),
		.restart_ack_o (restart_ack_o)
	);

	assign daq[0] = daq_ch0_i;
	assign daq[1] = daq_ch1_i;
	assign daq[2] = daq_ch2_i;
	assign daq[3] = daq_ch3_i;

	assign ch_restart = {pipe_pkg::NUM_CH{glob_restart}} | restart_ch_i;

	////////////////////////////////////////
	// Channels

	genvar c;
	generate
		for (c = 0; c < pipe_pkg::NUM_CH; c = c + 1) begin : g_ch
			pipe_channel u_channel (
				.CLK160    (CLK160),
				.trst      (trst),
				.restart_i (ch_restart[c]),    // Global or own restart
				.pdepth_i  (pdepth_i),
				.din_i     (daq[c]),
				.dout_o    (ch_dout[c]),
				.occ_o     (ch_occ[c]),
				.run_o     (chan_run_o[c])
			);
		end
	endgenerate

	assign occ0_o = ch_occ[0];
	assign occ1_o = ch_occ[1];
	assign occ2_o = ch_occ[2];
	assign occ3_o = ch_occ[3];

	////////////////////////////////////////
	// Group output registers

	always_ff @(posedge CLK160 or posedge trst) begin
		if (trst) begin
			grp0_o <= '0;
			grp1_o <= '0;
		end else begin
			grp0_o <= {ch_dout[1], ch_dout[0]};   // Odd channel on top
			grp1_o <= {ch_dout[3], ch_dout[2]};
		end
	end

endmodule

// ==== bench/pipe_checker.sv ====
`timescale 1ns/1ps

module pipe_checker (
	input  logic                        CLK160,
	input  logic                        trst,
	input  logic                        restart_req_i,
	input  logic                        restart_ack_i,
	input  logic                        restart_pulse_i,   // Global restart to the channels
	input  logic [pipe_pkg::NUM_CH-1:0] chan_run_i,
	input  logic [pipe_pkg::NUM_CH-1:0] fifo_full_i
);

	int fail_cnt = 0;                                      // Failed assertions so far

	ack_needs_req: assert property (@(posedge CLK160) disable iff (trst)
		$rose(restart_ack_i) |-> restart_req_i)
	else begin
		$error("restart acknowledge rose without a pending request");
		fail_cnt++;
	end

	// A new request only turns into a restart while the acknowledge is low
	restart_after_ack_low: assert property (@(posedge CLK160) disable iff (trst)
		restart_pulse_i |-> !restart_ack_i)
	else begin
		$error("restart issued while the acknowledge was still high");
		fail_cnt++;
	end

	ack_falls_after_req: assert property (@(posedge CLK160) disable iff (trst)
		(restart_ack_i && !restart_req_i) |=> !restart_ack_i)
	else begin
		$error("acknowledge stayed high after the request was released");
		fail_cnt++;
	end

	no_full_while_running: assert property (@(posedge CLK160) disable iff (trst)
		!(|(fifo_full_i & chan_run_i)))
	else begin
		$error("channel FIFO full while the channel runs");
		fail_cnt++;
	end

endmodule

// ==== bench/pipe_monitor.sv ====
`timescale 1ns/1ps

module pipe_monitor (
	input  logic                        CLK160,
	input  logic                        trst,
	input  logic                        restart_req_i,
	input  logic                        restart_ack_i,
	input  logic [pipe_pkg::NUM_CH-1:0] restart_ch_i,
	input  pipe_pkg::pdepth_t           pdepth_i,
	input  pipe_pkg::sample_t           daq_ch0_i,
	input  pipe_pkg::sample_t           daq_ch1_i,
	input  pipe_pkg::sample_t           daq_ch2_i,
	input  pipe_pkg::sample_t           daq_ch3_i,
	input  pipe_pkg::group_t            grp0_i,
	input  pipe_pkg::group_t            grp1_i,
	input  pipe_pkg::occ_t              occ0_i,
	input  pipe_pkg::occ_t              occ1_i,
	input  pipe_pkg::occ_t              occ2_i,
	input  pipe_pkg::occ_t              occ3_i,
	input  logic [pipe_pkg::NUM_CH-1:0] chan_run_i,
	output int                          err_cnt_o
);

	pipe_pkg::sample_t           hist [pipe_pkg::NUM_CH][pipe_pkg::FIFO_DEPTH]; // Input history
	pipe_pkg::sample_t           din  [pipe_pkg::NUM_CH];
	pipe_pkg::sample_t           dout [pipe_pkg::NUM_CH];
	pipe_pkg::occ_t              occ  [pipe_pkg::NUM_CH];
	int                          run_depth [pipe_pkg::NUM_CH];  // Depth of the current run
	int                          min_occ   [pipe_pkg::NUM_CH];  // Lowest count since run fell
	logic [pipe_pkg::NUM_CH-1:0] prev_run;
	logic [pipe_pkg::NUM_CH-1:0] restart_seen;
	logic                        prev_req;
	logic                        started;                       // Any restart since reset
	int                          wr_idx;
	int                          errors = 0;

	assign err_cnt_o = errors;

	assign din[0]  = daq_ch0_i;
	assign din[1]  = daq_ch1_i;
	assign din[2]  = daq_ch2_i;
	assign din[3]  = daq_ch3_i;
	assign dout[0] = grp0_i[pipe_pkg::SAMPLE_W-1:0];
	assign dout[1] = grp0_i[pipe_pkg::GROUP_W-1:pipe_pkg::SAMPLE_W];
	assign dout[2] = grp1_i[pipe_pkg::SAMPLE_W-1:0];
	assign dout[3] = grp1_i[pipe_pkg::GROUP_W-1:pipe_pkg::SAMPLE_W];
	assign occ[0]  = occ0_i;
	assign occ[1]  = occ1_i;
	assign occ[2]  = occ2_i;
	assign occ[3]  = occ3_i;

	function automatic string out_name(input int c);
		return $sformatf("grp%0d_o[%0d:%0d]", c / 2,
			(c % 2) * pipe_pkg::SAMPLE_W + pipe_pkg::SAMPLE_W - 1, (c % 2) * pipe_pkg::SAMPLE_W);
	endfunction

	task automatic compare(input string name, input logic [pipe_pkg::GROUP_W-1:0] exp_v,
			input logic [pipe_pkg::GROUP_W-1:0] act_v);
		if (exp_v !== act_v) begin
			$display("FAILED at %0t: %s expected %0h, got %0h", $time, name, exp_v, act_v);
			errors++;
		end
	endtask

	task automatic check_idle();
		compare("restart_ack_o", '0, restart_ack_i);
		compare("chan_run_o", '0, chan_run_i);
		compare("grp0_o", '0, grp0_i);
		compare("grp1_o", '0, grp1_i);
		for (int c = 0; c < pipe_pkg::NUM_CH; c++)
			compare($sformatf("occ%0d_o", c), '0, occ[c]);
	endtask

	////////////////////////////////////////
	// Delay-line model, sampled mid-cycle

	always @(negedge CLK160) begin
		int lag_idx;
		if (trst) begin
			prev_run     = '0;
			restart_seen = '0;
			prev_req     = 1'b0;
			started      = 1'b0;
			wr_idx       = 0;
			for (int c = 0; c < pipe_pkg::NUM_CH; c++) begin
				min_occ[c]   = 1023;
				run_depth[c] = 0;
			end
		end else begin
			if (restart_req_i || restart_ch_i != '0)
				started = 1'b1;
			if (!started)
				check_idle();
			for (int c = 0; c < pipe_pkg::NUM_CH; c++) begin
				hist[c][wr_idx] = din[c];
				if (chan_run_i[c] && !prev_run[c]) begin         // Run flag rose
					if (min_occ[c] != 0) begin
						$display("ERROR at %0t: channel %0d ran without its occupancy clearing",
							$time, c);
						errors++;
					end
					run_depth[c]    = int'(pdepth_i);
					restart_seen[c] = 1'b0;
				end else if (!chan_run_i[c] && prev_run[c]) begin // Run flag fell
					if (!restart_seen[c]) begin
						$display("ERROR at %0t: channel %0d stopped running without a restart",
							$time, c);
						errors++;
					end
					min_occ[c] = 1023;
				end
				if (!chan_run_i[c] && int'(occ[c]) < min_occ[c])
					min_occ[c] = int'(occ[c]);
				if (chan_run_i[c]) begin
					lag_idx = (wr_idx + pipe_pkg::FIFO_DEPTH - run_depth[c] - pipe_pkg::PIPE_LAT)
						% pipe_pkg::FIFO_DEPTH;
					compare(out_name(c), hist[c][lag_idx], dout[c]);
					compare($sformatf("occ%0d_o", c), run_depth[c] + pipe_pkg::RE_SYNC_STAGES,
						occ[c]);
				end
				if ((restart_req_i && !prev_req) || restart_ch_i[c])
					restart_seen[c] = 1'b1;
			end
			prev_run = chan_run_i;
			prev_req = restart_req_i;
			wr_idx   = (wr_idx + 1) % pipe_pkg::FIFO_DEPTH;
		end
	end

endmodule

// ==== bench/tb_pipeline_gen.sv ====
`timescale 1ns/1ps

module tb_pipeline_gen;

	localparam int N_RAND       = 6;     // Random depths in the last phase
	localparam int IDLE_CYCLES  = 50;
	localparam int RUN_CYCLES   = 120;   // Checked cycles per phase
	localparam int HS_LIMIT     = 600;
	localparam int PHASE_MARGIN = 200;

	logic                        CLK160;
	logic                        trst;
	logic                        restart_req;
	logic                        restart_ack;
	logic [pipe_pkg::NUM_CH-1:0] restart_ch;
	pipe_pkg::pdepth_t           pdepth;
	pipe_pkg::sample_t           daq_ch0, daq_ch1, daq_ch2, daq_ch3;
	pipe_pkg::group_t            grp0, grp1;
	pipe_pkg::occ_t              occ0, occ1, occ2, occ3;
	logic [pipe_pkg::NUM_CH-1:0] chan_run;
	int                          mon_errors;
	int                          hs_errors = 0;
	int                          cycle_cnt;
	int                          cycle_limit;
	int                          rand_depth [N_RAND];
	integer                      seed;

	pipeline_gen dut_i (
		.CLK160 (CLK160), .trst (trst),
		.restart_req_i (restart_req), .restart_ack_o (restart_ack),
		.restart_ch_i (restart_ch), .pdepth_i (pdepth),
		.daq_ch0_i (daq_ch0), .daq_ch1_i (daq_ch1), .daq_ch2_i (daq_ch2), .daq_ch3_i (daq_ch3),
		.grp0_o (grp0), .grp1_o (grp1),
		.occ0_o (occ0), .occ1_o (occ1), .occ2_o (occ2), .occ3_o (occ3),
		.chan_run_o (chan_run)
	);

	pipe_monitor u_monitor (
		.CLK160 (CLK160), .trst (trst),
		.restart_req_i (restart_req), .restart_ack_i (restart_ack),
		.restart_ch_i (restart_ch), .pdepth_i (pdepth),
		.daq_ch0_i (daq_ch0), .daq_ch1_i (daq_ch1), .daq_ch2_i (daq_ch2), .daq_ch3_i (daq_ch3),
		.grp0_i (grp0), .grp1_i (grp1),
		.occ0_i (occ0), .occ1_i (occ1), .occ2_i (occ2), .occ3_i (occ3),
		.chan_run_i (chan_run), .err_cnt_o (mon_errors)
	);

	bind pipeline_gen pipe_checker u_checker (
		.CLK160 (CLK160), .trst (trst),
		.restart_req_i (restart_req_i), .restart_ack_i (restart_ack_o),
		.restart_pulse_i (glob_restart), .chan_run_i (chan_run_o),
		.fifo_full_i ({g_ch[3].u_channel.fifo_full, g_ch[2].u_channel.fifo_full,
			g_ch[1].u_channel.fifo_full, g_ch[0].u_channel.fifo_full})
	);

	always #4 CLK160 = ~CLK160;

	function automatic pipe_pkg::sample_t random_word();
		return {$random(seed), $random(seed), $random(seed)};
	endfunction

	always @(posedge CLK160) begin                  // New word on every channel each cycle
		daq_ch0 <= random_word();
		daq_ch1 <= random_word();
		daq_ch2 <= random_word();
		daq_ch3 <= random_word();
	end

	task automatic finish_run(input bit timed_out);
		int total;
		total = mon_errors + hs_errors + dut_i.u_checker.fail_cnt + int'(timed_out);
		$display("Errors: monitor %0d, handshake %0d, assertion %0d, timeout %0d",
			mon_errors, hs_errors, dut_i.u_checker.fail_cnt, timed_out);
		if (total == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	endtask

	always @(posedge CLK160) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == cycle_limit) begin
			$display("ERROR: run stopped at the limit of %0d cycles", cycle_limit);
			finish_run(1'b1);
		end
	end

	////////////////////////////////////////
	// Restart drivers

	task automatic global_restart(input int depth);
		int waited;
		@(posedge CLK160);
		pdepth <= pipe_pkg::pdepth_t'(depth);
		@(posedge CLK160);
		restart_req <= 1'b1;
		waited = 0;
		do begin
			@(negedge CLK160);
			waited++;
		end while (!restart_ack && waited < HS_LIMIT);
		if (!restart_ack) begin
			$display("ERROR at %0t: no acknowledge for the restart with depth %0d", $time, depth);
			hs_errors++;
		end
		@(posedge CLK160);
		restart_req <= 1'b0;                        // Release, ack must follow
		waited = 0;
		do begin
			@(negedge CLK160);
			waited++;
		end while (restart_ack && waited < 4);
		if (restart_ack) begin
			$display("ERROR at %0t: acknowledge did not fall after the request", $time);
			hs_errors++;
		end
	endtask

	task automatic restart_channel(input int ch);
		int waited;
		@(posedge CLK160);
		restart_ch[ch] <= 1'b1;
		@(posedge CLK160);
		restart_ch <= '0;
		waited = 0;
		do begin
			@(negedge CLK160);
			waited++;
		end while (chan_run[ch] && waited < 4);
		if (chan_run[ch]) begin
			$display("ERROR at %0t: channel %0d kept running after its restart", $time, ch);
			hs_errors++;
		end
		waited = 0;
		while (!chan_run[ch] && waited < HS_LIMIT) begin
			@(negedge CLK160);
			waited++;
		end
		if (!chan_run[ch]) begin
			$display("ERROR at %0t: channel %0d never returned to running", $time, ch);
			hs_errors++;
		end
	endtask

	initial begin
		CLK160      = 1'b0;
		trst        = 1'b1;
		restart_req = 1'b0;
		restart_ch  = '0;
		pdepth      = '0;
		daq_ch0     = '0;
		daq_ch1     = '0;
		daq_ch2     = '0;
		daq_ch3     = '0;
		cycle_cnt   = 0;
		seed        = 32'h1952;
		for (int i = 0; i < N_RAND; i++)
			rand_depth[i] = 1 + ($unsigned($random(seed)) % 400);
		// Reset, idle, depth 20, depth 300 and the channel 2 restart
		cycle_limit = 16 + 4 * PHASE_MARGIN + 20 + 300 + 300;
		for (int i = 0; i < N_RAND; i++)
			cycle_limit += rand_depth[i] + PHASE_MARGIN;
		repeat (16) @(posedge CLK160);
		trst <= 1'b0;
		repeat (IDLE_CYCLES) @(posedge CLK160);   // Outputs must stay quiet
		global_restart(20);
		repeat (RUN_CYCLES) @(posedge CLK160);
		global_restart(300);
		repeat (RUN_CYCLES) @(posedge CLK160);
		restart_channel(2);
		repeat (RUN_CYCLES) @(posedge CLK160);
		for (int i = 0; i < N_RAND; i++) begin
			global_restart(rand_depth[i]);
			repeat (RUN_CYCLES) @(posedge CLK160);
		end
		finish_run(1'b0);
	end

endmodule

// ==== project.f ====
rtl/pipe_pkg.sv
rtl/pipe_fifo.sv
rtl/pipe_start_fsm.sv
rtl/pipe_channel.sv
rtl/pipe_restart_ctrl.sv
rtl/pipeline_gen.sv
bench/pipe_checker.sv
bench/pipe_monitor.sv
bench/tb_pipeline_gen.sv
